/* common/chroni_pkg.sv */
package chroni_pkg;

   // CPU register window, 16 addresses from reg_base.
   localparam logic [15:0] reg_base      = 16'h9000;
   localparam logic [3:0]  reg_pal_index = 4'd4;
   localparam logic [3:0]  reg_pal_value = 4'd5;  // Low byte, then high byte.
   localparam logic [3:0]  reg_fg        = 4'd6;
   localparam logic [3:0]  reg_bg        = 4'd7;

   localparam int vram_aw = 13;  // 8 KB video RAM.
   localparam int pal_aw  = 8;
   localparam int pal_dw  = 16;  // RGB565.

   // Font glyphs are 8 bytes each, one per font row.
   localparam logic [vram_aw-1:0] font_base = 13'h1000;

   typedef enum logic [1:0] {
      pal_idle,
      pal_lo,
      pal_hi,
      pal_commit
   } pal_state_t;

   typedef enum logic [2:0] {
      fd_idle,
      fd_text_read,
      fd_font_read,
      fd_font_fetch,
      fd_font_wait,
      fd_font_write,
      fd_font_done
   } fd_state_t;

endpackage

/* common/line_write_if.sv */
`timescale 1ns/1ps

interface line_write_if #(
   parameter int cols = 80
);

   localparam int aw = $clog2(2 * cols * 8);  // Two line halves.

   logic          wr_en;
   logic [aw-1:0] wr_addr;    // First pixel of the byte.
   logic [7:0]    wr_bits;
   logic [7:0]    on_index;
   logic [7:0]    off_index;
   logic          busy;       // High while the byte is expanded.

   modport gen (
      output wr_en, wr_addr, wr_bits, on_index, off_index,
      input  busy
   );

   modport buffer (
      input  wr_en, wr_addr, wr_bits, on_index, off_index,
      output busy
   );

endinterface

/* hw/chroni_ram.sv */
`timescale 1ns/1ps

module chroni_ram #(
   parameter  int depth = 256,
   parameter  int width = 8,
   localparam int aw    = $clog2(depth)
) (
   input  logic             sys_clk,
   input  logic             wr_en,
   input  logic [aw-1:0]    wr_addr,
   input  logic [width-1:0] wr_data,
   input  logic [aw-1:0]    rd_addr,
   output logic [width-1:0] rd_data
);

   logic [width-1:0] mem [depth];

   always_ff @(posedge sys_clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      rd_data <= mem[rd_addr];  // One cycle read latency.
   end

endmodule

/* hw/chroni_regs.sv */
`timescale 1ns/1ps

module chroni_regs (
   input  logic                            sys_clk,
   input  logic                            rst,
   input  logic [15:0]                     cpu_addr,
   input  logic [7:0]                      cpu_wr_data,
   input  logic                            cpu_wr_en,
   output logic                            pal_wr_en,
   output logic [chroni_pkg::pal_aw-1:0]   pal_wr_addr,
   output logic [chroni_pkg::pal_dw-1:0]   pal_wr_data,
   output logic                            vram_wr_en,
   output logic [chroni_pkg::vram_aw-1:0]  vram_wr_addr,
   output logic [7:0]                      vram_wr_data,
   output logic [7:0]                      fg_index,
   output logic [7:0]                      bg_index
);

   chroni_pkg::pal_state_t            pal_state;
   logic [chroni_pkg::pal_aw-1:0]     pal_index;
   logic [chroni_pkg::pal_dw-1:0]     pal_value;
   logic                              reg_cs;

   assign reg_cs = cpu_wr_en && (cpu_addr[15:4] == chroni_pkg::reg_base[15:4]);

   // Lower half of the address space maps straight onto VRAM.
   assign vram_wr_en   = cpu_wr_en && !cpu_addr[15];
   assign vram_wr_addr = cpu_addr[chroni_pkg::vram_aw-1:0];
   assign vram_wr_data = cpu_wr_data;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         pal_state <= chroni_pkg::pal_idle;
         pal_wr_en <= 1'b0;
         fg_index  <= 8'd1;
         bg_index  <= 8'd0;
      end else begin
         pal_wr_en <= 1'b0;
         if (reg_cs) begin
            case (cpu_addr[3:0])
               chroni_pkg::reg_pal_index: begin
                  pal_index <= cpu_wr_data;
                  pal_state <= chroni_pkg::pal_lo;
               end
               chroni_pkg::reg_pal_value: begin
                  if (pal_state == chroni_pkg::pal_lo) begin
                     pal_value[7:0] <= cpu_wr_data;
                     pal_state      <= chroni_pkg::pal_hi;
                  end else if (pal_state == chroni_pkg::pal_hi) begin
                     pal_value[15:8] <= cpu_wr_data;
                     pal_state       <= chroni_pkg::pal_commit;
                  end
               end
               chroni_pkg::reg_fg: fg_index <= cpu_wr_data;
               chroni_pkg::reg_bg: bg_index <= cpu_wr_data;
               default: ;
            endcase
         end else if (pal_state == chroni_pkg::pal_commit) begin
            pal_wr_en   <= 1'b1;
            pal_wr_addr <= pal_index;
            pal_wr_data <= pal_value;
            pal_index   <= pal_index + 1'b1;  // Ready for the next entry.
            pal_state   <= chroni_pkg::pal_lo;
         end
      end
   end

endmodule

/* char_gen/chroni_char_gen.sv */
`timescale 1ns/1ps

module chroni_char_gen #(
   parameter  int cols = 80,
   parameter  int rows = 30,
   localparam int lnw  = $clog2(rows * 8)
) (
   input  logic                           sys_clk,
   input  logic                           rst,
   input  logic                           line_start,
   input  logic [lnw-1:0]                 line_num,
   input  logic [7:0]                     fg_index,
   input  logic [7:0]                     bg_index,
   output logic [chroni_pkg::vram_aw-1:0] vram_rd_addr,
   input  logic [7:0]                     vram_rd_data,
   line_write_if.gen                      lw
);

   localparam int vaw   = chroni_pkg::vram_aw;
   localparam int tw    = $clog2(cols);
   localparam int lb_aw = $clog2(2 * cols * 8);
   localparam logic [tw-1:0] last_idx = tw'(cols - 1);

   chroni_pkg::fd_state_t state;
   logic                  mem_wait;
   logic [tw-1:0]         text_idx;
   logic [2:0]            font_row;
   logic [lb_aw-1:0]      pix_addr;
   logic [vaw-1:0]        text_base;

   logic                  tb_wr_en;
   logic [tw-1:0]         tb_wr_addr;
   logic [7:0]            tb_wr_data;
   logic [tw-1:0]         tb_rd_addr;
   logic [7:0]            tb_rd_data;

   // Start of the character row in VRAM.
   assign text_base = vaw'((line_num >> 3) * cols);

   chroni_ram #(
      .depth (cols),
      .width (8)
   ) text_buffer (
      .sys_clk (sys_clk),
      .wr_en   (tb_wr_en),
      .wr_addr (tb_wr_addr),
      .wr_data (tb_wr_data),
      .rd_addr (tb_rd_addr),
      .rd_data (tb_rd_data)
   );

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         state    <= chroni_pkg::fd_idle;
         mem_wait <= 1'b0;
         tb_wr_en <= 1'b0;
         lw.wr_en <= 1'b0;
      end else begin
         tb_wr_en <= 1'b0;
         lw.wr_en <= 1'b0;
         case (state)
            chroni_pkg::fd_idle: begin
               if (line_start) begin
                  font_row   <= line_num[2:0];
                  pix_addr   <= line_num[0] ? lb_aw'(cols * 8) : '0;
                  text_idx   <= '0;
                  tb_rd_addr <= '0;
                  mem_wait   <= 1'b1;
                  if (line_num[2:0] == 3'd0) begin
                     vram_rd_addr <= text_base;
                     state        <= chroni_pkg::fd_text_read;
                  end else begin
                     state <= chroni_pkg::fd_font_read;
                  end
               end
            end
            chroni_pkg::fd_text_read: begin
               // Addresses stream one per cycle, data trails by two.
               vram_rd_addr <= vram_rd_addr + 1'b1;
               if (mem_wait) begin
                  mem_wait <= 1'b0;
               end else begin
                  tb_wr_en   <= 1'b1;
                  tb_wr_addr <= text_idx;
                  tb_wr_data <= vram_rd_data;
                  if (text_idx == last_idx) begin
                     text_idx <= '0;
                     mem_wait <= 1'b1;
                     state    <= chroni_pkg::fd_font_read;
                  end else begin
                     text_idx <= text_idx + 1'b1;
                  end
               end
            end
            chroni_pkg::fd_font_read: begin
               if (mem_wait) begin
                  mem_wait <= 1'b0;
               end else begin
                  state <= chroni_pkg::fd_font_fetch;
               end
            end
            chroni_pkg::fd_font_fetch: begin
               vram_rd_addr <= chroni_pkg::font_base + vaw'({tb_rd_data, font_row});
               if (text_idx != last_idx) begin
                  tb_rd_addr <= text_idx + 1'b1;  // Next code in advance.
               end
               mem_wait <= 1'b1;
               state    <= chroni_pkg::fd_font_wait;
            end
            chroni_pkg::fd_font_wait: begin
               if (mem_wait) begin
                  mem_wait <= 1'b0;
               end else begin
                  lw.wr_bits <= vram_rd_data;
                  state      <= chroni_pkg::fd_font_write;
               end
            end
            chroni_pkg::fd_font_write: begin
               if (!lw.busy) begin
                  lw.wr_en     <= 1'b1;
                  lw.wr_addr   <= pix_addr;
                  lw.on_index  <= fg_index;
                  lw.off_index <= bg_index;
                  state        <= chroni_pkg::fd_font_done;
               end
            end
            chroni_pkg::fd_font_done: begin
               if (text_idx == last_idx) begin
                  state <= chroni_pkg::fd_idle;
               end else begin
                  text_idx <= text_idx + 1'b1;
                  pix_addr <= pix_addr + lb_aw'(8);
                  state    <= chroni_pkg::fd_font_read;
               end
            end
            default: state <= chroni_pkg::fd_idle;
         endcase
      end
   end

   // A new line must not be requested before the last one is built.
   line_start_idle: assert property (@(posedge sys_clk) disable iff (rst)
      line_start |-> state == chroni_pkg::fd_idle);

endmodule

/* hw/chroni_line_buffer.sv */
`timescale 1ns/1ps

module chroni_line_buffer #(
   parameter  int cols = 80,
   localparam int aw   = $clog2(2 * cols * 8)
) (
   input  logic          sys_clk,
   input  logic          rst,
   line_write_if.buffer  lw,
   input  logic [aw-1:0] rd_addr,
   output logic [7:0]    rd_index
);

   localparam int depth = 2 * cols * 8;

   logic [7:0]    mem [depth];
   logic [2:0]    cnt;
   logic [aw-1:0] base_addr;
   logic [7:0]    bits;
   logic [7:0]    on_idx;
   logic [7:0]    off_idx;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         lw.busy <= 1'b0;
         cnt     <= 3'd0;
      end else if (lw.wr_en && !lw.busy) begin
         lw.busy <= 1'b1;
         cnt     <= 3'd0;
      end else if (lw.busy) begin
         cnt <= cnt + 1'b1;
         if (cnt == 3'd7) begin
            lw.busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (lw.wr_en && !lw.busy) begin
         base_addr <= lw.wr_addr;
         bits      <= lw.wr_bits;
         on_idx    <= lw.on_index;
         off_idx   <= lw.off_index;
      end else if (lw.busy) begin
         mem[base_addr + aw'(cnt)] <= bits[7] ? on_idx : off_idx;  // MSB first.
         bits <= bits << 1;
      end
      rd_index <= mem[rd_addr];
   end

   // Writer must honour busy, or a byte is lost mid-expansion.
   no_write_while_busy: assert property (@(posedge sys_clk) disable iff (rst)
      lw.busy |-> !lw.wr_en);

endmodule

/* hw/chroni_video_timing.sv */
`timescale 1ns/1ps

module chroni_video_timing #(
   parameter  int cols    = 80,
   parameter  int rows    = 30,
   parameter  int h_blank = 160,
   parameter  int v_blank = 45,
   localparam int lnw     = $clog2(rows * 8),
   localparam int lb_aw   = $clog2(2 * cols * 8)
) (
   input  logic             sys_clk,
   input  logic             rst,
   output logic             line_start,
   output logic [lnw-1:0]   line_num,
   output logic [lb_aw-1:0] lb_rd_addr,
   output logic [7:0]       pal_rd_addr,
   input  logic [15:0]      pal_rd_data,
   input  logic [7:0]       lb_rd_index,
   output logic [4:0]       vga_r,
   output logic [5:0]       vga_g,
   output logic [4:0]       vga_b,
   output logic             vga_hs,
   output logic             vga_vs,
   output logic             vga_de
);

   localparam int h_vis   = cols * 8;
   localparam int h_total = h_vis + h_blank;
   localparam int v_vis   = rows * 8;
   localparam int v_total = v_vis + v_blank;
   localparam int hw      = $clog2(h_total);
   localparam int vw      = $clog2(v_total);

   logic [hw-1:0] h_cnt;
   logic [vw-1:0] v_cnt;
   logic          vis;
   logic          hs_now;
   logic          vs_now;
   logic [1:0]    de_pipe;
   logic [1:0]    hs_pipe;
   logic [1:0]    vs_pipe;

   // Starts on the last blank line so line 0 is built first.
   always_ff @(posedge sys_clk) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= vw'(v_total - 1);
      end else if (h_cnt == hw'(h_total - 1)) begin
         h_cnt <= '0;
         v_cnt <= (v_cnt == vw'(v_total - 1)) ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   assign vis    = (h_cnt < hw'(h_vis)) && (v_cnt < vw'(v_vis));
   assign hs_now = (h_cnt >= hw'(h_vis)) && (h_cnt < hw'(h_vis + 8));
   assign vs_now = (v_cnt == vw'(v_vis));

   // Request the next visible line one line ahead.
   assign line_start = (h_cnt == '0) &&
                       ((v_cnt == vw'(v_total - 1)) || (v_cnt < vw'(v_vis - 1)));
   assign line_num   = (v_cnt == vw'(v_total - 1)) ? '0 : lnw'(v_cnt + 1'b1);

   // Scan-out reads the half not being built.
   assign lb_rd_addr = (h_cnt >= hw'(h_vis)) ? '0 :
                       v_cnt[0] ? lb_aw'(h_vis) + lb_aw'(h_cnt) : lb_aw'(h_cnt);
   assign pal_rd_addr = lb_rd_index;

   always_ff @(posedge sys_clk) begin
      if (rst) begin
         de_pipe <= '0;
         hs_pipe <= '0;
         vs_pipe <= '0;
         vga_de  <= 1'b0;
         vga_hs  <= 1'b0;
         vga_vs  <= 1'b0;
         vga_r   <= '0;
         vga_g   <= '0;
         vga_b   <= '0;
      end else begin
         de_pipe <= {de_pipe[0], vis};
         hs_pipe <= {hs_pipe[0], hs_now};
         vs_pipe <= {vs_pipe[0], vs_now};
         vga_de  <= de_pipe[1];
         vga_hs  <= hs_pipe[1];
         vga_vs  <= vs_pipe[1];
         vga_r   <= de_pipe[1] ? pal_rd_data[15:11] : '0;
         vga_g   <= de_pipe[1] ? pal_rd_data[10:5]  : '0;
         vga_b   <= de_pipe[1] ? pal_rd_data[4:0]   : '0;
      end
   end

endmodule

/* hw/chroni_top.sv */
`timescale 1ns/1ps

module chroni_top #(
   parameter int cols    = 80,
   parameter int rows    = 30,
   parameter int h_blank = 160,
   parameter int v_blank = 45
) (
   input  logic        sys_clk,
   input  logic        rst,
   input  logic [15:0] cpu_addr,
   input  logic [7:0]  cpu_wr_data,
   input  logic        cpu_wr_en,
   output logic [4:0]  vga_r,
   output logic [5:0]  vga_g,
   output logic [4:0]  vga_b,
   output logic        vga_hs,
   output logic        vga_vs,
   output logic        vga_de
);

   localparam int lnw   = $clog2(rows * 8);
   localparam int lb_aw = $clog2(2 * cols * 8);

   logic                           pal_wr_en;
   logic [chroni_pkg::pal_aw-1:0]  pal_wr_addr;
   logic [chroni_pkg::pal_dw-1:0]  pal_wr_data;
   logic [chroni_pkg::pal_aw-1:0]  pal_rd_addr;
   logic [chroni_pkg::pal_dw-1:0]  pal_rd_data;
   logic                           vram_wr_en;
   logic [chroni_pkg::vram_aw-1:0] vram_wr_addr;
   logic [7:0]                     vram_wr_data;
   logic [chroni_pkg::vram_aw-1:0] vram_rd_addr;
   logic [7:0]                     vram_rd_data;
   logic [7:0]                     fg_index;
   logic [7:0]                     bg_index;
   logic                           line_start;
   logic [lnw-1:0]                 line_num;
   logic [lb_aw-1:0]               lb_rd_addr;
   logic [7:0]                     lb_rd_index;

   line_write_if #(.cols(cols)) line_wr ();

   chroni_regs regs0 (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .cpu_addr     (cpu_addr),
      .cpu_wr_data  (cpu_wr_data),
      .cpu_wr_en    (cpu_wr_en),
      .pal_wr_en    (pal_wr_en),
      .pal_wr_addr  (pal_wr_addr),
      .pal_wr_data  (pal_wr_data),
      .vram_wr_en   (vram_wr_en),
      .vram_wr_addr (vram_wr_addr),
      .vram_wr_data (vram_wr_data),
      .fg_index     (fg_index),
      .bg_index     (bg_index)
   );

   chroni_ram #(
      .depth (1 << chroni_pkg::vram_aw),
      .width (8)
   ) vram0 (
      .sys_clk (sys_clk),
      .wr_en   (vram_wr_en),
      .wr_addr (vram_wr_addr),
      .wr_data (vram_wr_data),
      .rd_addr (vram_rd_addr),
      .rd_data (vram_rd_data)
   );

   chroni_ram #(
      .depth (1 << chroni_pkg::pal_aw),
      .width (chroni_pkg::pal_dw)
   ) palette0 (
      .sys_clk (sys_clk),
      .wr_en   (pal_wr_en),
      .wr_addr (pal_wr_addr),
      .wr_data (pal_wr_data),
      .rd_addr (pal_rd_addr),
      .rd_data (pal_rd_data)
   );

   chroni_char_gen #(
      .cols (cols),
      .rows (rows)
   ) char_gen0 (
      .sys_clk      (sys_clk),
      .rst          (rst),
      .line_start   (line_start),
      .line_num     (line_num),
      .fg_index     (fg_index),
      .bg_index     (bg_index),
      .vram_rd_addr (vram_rd_addr),
      .vram_rd_data (vram_rd_data),
      .lw           (line_wr.gen)
   );

   chroni_line_buffer #(
      .cols (cols)
   ) line_buf0 (
      .sys_clk  (sys_clk),
      .rst      (rst),
      .lw       (line_wr.buffer),
      .rd_addr  (lb_rd_addr),
      .rd_index (lb_rd_index)
   );

   chroni_video_timing #(
      .cols    (cols),
      .rows    (rows),
      .h_blank (h_blank),
      .v_blank (v_blank)
   ) timing0 (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .line_start  (line_start),
      .line_num    (line_num),
      .lb_rd_addr  (lb_rd_addr),
      .pal_rd_addr (pal_rd_addr),
      .pal_rd_data (pal_rd_data),
      .lb_rd_index (lb_rd_index),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_de      (vga_de)
   );

endmodule

/* sim/chroni_tb.sv */
`timescale 1ns/1ps

module chroni_tb;

   localparam int cols         = 10;
   localparam int rows         = 3;
   localparam int h_blank      = 120;
   localparam int v_blank      = 4;
   localparam int h_total      = cols * 8 + h_blank;
   localparam int frame_cycles = h_total * (rows * 8 + v_blank);
   localparam int frame_pixels = cols * 8 * rows * 8;
   localparam int test_frames  = 20;  // Checked frames plus the waits between them.
   localparam int write_count  = 1 + 2 * 16 + 2 * (cols * rows + 128) + 2 * 10 + 8;
   localparam int watchdog_cycles = 20 + test_frames * frame_cycles + 2 * write_count;

   logic        sys_clk;
   logic        rst;
   logic [15:0] cpu_addr;
   logic [7:0]  cpu_wr_data;
   logic        cpu_wr_en;
   logic [4:0]  vga_r;
   logic [5:0]  vga_g;
   logic [4:0]  vga_b;
   logic        vga_hs;
   logic        vga_vs;
   logic        vga_de;

   logic [31:0] lfsr_state = 32'h1060_c2b1;
   logic [7:0]  vram_model [8192];
   logic [15:0] pal_model [256];
   logic [7:0]  fg_model;
   logic [7:0]  bg_model;

   string       test_name;
   int          test_errors;
   int          tests_passed;
   int          tests_failed;
   logic        frame_armed = 1'b0;
   int          pix_x;
   int          pix_y;
   int          pixels_seen;
   logic [15:0] exp_rgb;
   logic [15:0] dut_rgb;

   chroni_top #(
      .cols    (cols),
      .rows    (rows),
      .h_blank (h_blank),
      .v_blank (v_blank)
   ) dut0 (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .cpu_addr    (cpu_addr),
      .cpu_wr_data (cpu_wr_data),
      .cpu_wr_en   (cpu_wr_en),
      .vga_r       (vga_r),
      .vga_g       (vga_g),
      .vga_b       (vga_b),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_de      (vga_de)
   );

   initial begin
      sys_clk = 1'b0;
      forever #2 sys_clk = ~sys_clk;
   end

   // Galois LFSR on x^32 + x^22 + x^2 + x + 1.
   function automatic logic [15:0] random_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
         v = {v[14:0], lfsr_state[0]};  // One step per bit.
      end
      return v;
   endfunction

   // Text code from the row, then the glyph bit, then the palette entry.
   function automatic logic [15:0] expected_rgb(input int x, input int y);
      logic [7:0] code;
      logic [7:0] glyph;
      code  = vram_model[13'((y / 8) * cols + x / 8)];
      glyph = vram_model[13'('h1000 + int'(code) * 8 + y % 8)];
      return glyph[3'(7 - x % 8)] ? pal_model[fg_model] : pal_model[bg_model];
   endfunction

   function automatic logic [15:0] reg_addr(input logic [3:0] offset);
      return {chroni_pkg::reg_base[15:4], offset};
   endfunction

   task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge sys_clk);
      cpu_addr    <= addr;
      cpu_wr_data <= data;
      cpu_wr_en   <= 1'b1;
      @(posedge sys_clk);
      cpu_wr_en   <= 1'b0;  // Idle cycle lets a palette entry commit.
   endtask

   task automatic write_vram(input int addr, input logic [7:0] data);
      cpu_write(16'(addr), data);
      vram_model[13'(addr)] = data;
   endtask

   task automatic load_palette(input int first, input int count);
      logic [15:0] value;
      cpu_write(reg_addr(chroni_pkg::reg_pal_index), 8'(first));
      for (int i = 0; i < count; i++) begin
         value = random_bits(16);
         cpu_write(reg_addr(chroni_pkg::reg_pal_value), value[7:0]);
         cpu_write(reg_addr(chroni_pkg::reg_pal_value), value[15:8]);
         pal_model[8'(first + i)] = value;
      end
   endtask

   task automatic load_text_and_font();
      for (int i = 0; i < cols * rows; i++) begin
         write_vram(i, 8'(random_bits(4)));
      end
      for (int i = 0; i < 16 * 8; i++) begin
         write_vram('h1000 + i, 8'(random_bits(8)));
      end
   endtask

   task automatic set_colours(input logic [7:0] fg, input logic [7:0] bg);
      cpu_write(reg_addr(chroni_pkg::reg_fg), fg);
      cpu_write(reg_addr(chroni_pkg::reg_bg), bg);
      fg_model = fg;
      bg_model = bg;
   endtask

   task automatic compare_count(input string what, input int expected, input int actual);
      assert (actual == expected) else begin
         $display("mismatch %s %s: expected %0d, actual %0d",
                  test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_idle_outputs();
      logic [18:0] outs;
      outs = {vga_de, vga_hs, vga_vs, vga_r, vga_g, vga_b};
      assert (outs === '0) else begin
         $display("mismatch %s: expected %05h, actual %05h", test_name, 19'h0, outs);
         test_errors++;
      end
   endtask

   // Lines are built one line ahead, so a frame is whole from the end of vs.
   task automatic check_frame();
      @(negedge vga_vs);
      pixels_seen = 0;
      frame_armed = 1'b1;
      @(posedge vga_vs);
      frame_armed = 1'b0;
      compare_count("visible pixels", frame_pixels, pixels_seen);
   endtask

   task automatic check_sync();
      int   de_run;
      int   de_lines;
      int   hs_pulses;
      int   vs_pulses;
      logic de_q;
      logic hs_q;
      logic vs_q;
      de_run    = 0;
      de_lines  = 0;
      hs_pulses = 0;
      vs_pulses = 0;
      de_q      = 1'b0;
      hs_q      = 1'b0;
      vs_q      = 1'b0;
      @(negedge vga_vs);
      repeat (frame_cycles) begin
         @(negedge sys_clk);
         if (vga_hs && !hs_q) hs_pulses++;
         if (vga_vs && !vs_q) vs_pulses++;
         if (vga_de) de_run++;
         if (!vga_de && de_q) begin
            de_lines++;
            compare_count("de cycles per line", cols * 8, de_run);
            de_run = 0;
         end
         de_q = vga_de;
         hs_q = vga_hs;
         vs_q = vga_vs;
      end
      compare_count("visible lines", rows * 8, de_lines);
      compare_count("hs pulses", rows * 8 + v_blank, hs_pulses);
      compare_count("vs pulses", 1, vs_pulses);
   endtask

   task automatic update_text_mid_frame();
      int pos;
      @(posedge vga_vs);
      repeat (h_total * (v_blank + rows * 4)) @(posedge sys_clk);
      for (int i = 0; i < 8; i++) begin
         pos = int'(random_bits(5)) % (cols * rows);
         write_vram(pos, 8'(random_bits(4)));
      end
      @(negedge vga_vs);  // Skip the frame that follows the writes.
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      if (test_errors == 0) begin
         $display("pass  %s", test_name);
         tests_passed++;
      end else begin
         $display("fail  %s, %0d errors", test_name, test_errors);
         tests_failed++;
      end
   endtask

   always @(negedge sys_clk) begin
      if (rst || vga_vs) begin
         pix_x = 0;
         pix_y = 0;
      end else if (vga_de) begin
         if (frame_armed) begin
            exp_rgb = expected_rgb(pix_x, pix_y);
            dut_rgb = {vga_r, vga_g, vga_b};
            pixels_seen++;
            assert (dut_rgb === exp_rgb) else begin
               if (test_errors < 10) begin
                  $display("mismatch %s at (%0d,%0d): expected %04h, actual %04h",
                           test_name, pix_x, pix_y, exp_rgb, dut_rgb);
               end
               test_errors++;
            end
         end
         pix_x++;
         if (pix_x == cols * 8) begin
            pix_x = 0;
            pix_y++;
         end
      end
   end

   initial begin : watchdog
      repeat (watchdog_cycles) @(posedge sys_clk);
      $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
      $display("Test FAILED");
      $finish;
   end

   initial begin : main
      logic [7:0] new_fg;
      logic [7:0] new_bg;
      rst         = 1'b1;
      cpu_addr    = '0;
      cpu_wr_data = '0;
      cpu_wr_en   = 1'b0;
      fg_model    = 8'd1;  // Reset values of the colour registers.
      bg_model    = 8'd0;

      start_test("reset_levels");
      @(posedge sys_clk);
      for (int i = 1; i < 20; i++) begin
         @(negedge sys_clk);
         check_idle_outputs();
         @(posedge sys_clk);
         if (i == 15) begin
            rst <= 1'b0;
         end
      end
      finish_test();

      // Eight fg/bg pairs cover all 16 entries.
      start_test("palette_auto_increment");
      load_palette(0, 16);
      load_text_and_font();
      for (int k = 0; k < 8; k++) begin
         set_colours(8'(2 * k + 1), 8'(2 * k));
         check_frame();
      end
      finish_test();

      start_test("text_font_rendering");
      load_text_and_font();
      set_colours(8'd1, 8'd0);
      check_frame();
      finish_test();

      // Both new indices differ from the current pair 1 and 0.
      start_test("colour_registers");
      new_fg = 8'(random_bits(3)) + 8'd2;
      new_bg = new_fg + 8'(random_bits(2)) + 8'd1;
      set_colours(new_fg, new_bg);
      check_frame();
      finish_test();

      start_test("sync_structure");
      check_sync();
      finish_test();

      start_test("live_text_update");
      update_text_mid_frame();
      check_frame();
      finish_test();

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
common/chroni_pkg.sv
common/line_write_if.sv
hw/chroni_ram.sv
hw/chroni_regs.sv
char_gen/chroni_char_gen.sv
hw/chroni_line_buffer.sv
hw/chroni_video_timing.sv
hw/chroni_top.sv
sim/chroni_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the chroni testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module chroni_tb -f project.f -o chroni_sim

status=0
./obj_dir/chroni_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test FAILED" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi

echo "simulation passed"
